// File: design/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

    // Word geometry
    parameter int LANES    = 4;
    parameter int CODE_W   = 8;
    parameter int WEIGHT_W = 8;
    parameter int EST_W    = 18;
    parameter int ERR_W    = 19;
    parameter int MAX_TAPS = 4;
    parameter int SHIFT_W  = 4;

    // Lane 0 holds the earliest sample
    typedef logic signed [CODE_W-1:0] code_t;
    typedef code_t [LANES-1:0] code_word_t;

    typedef logic signed [EST_W-1:0] est_t;
    typedef est_t [LANES-1:0] est_word_t;

    typedef logic signed [ERR_W-1:0] err_t;

    // 1 is symbol +1, 0 is symbol -1
    typedef logic [LANES-1:0] bit_word_t;

    // Tap 0 weights the current sample
    typedef logic signed [WEIGHT_W-1:0] tap_t;
    typedef tap_t [MAX_TAPS-1:0] tap_set_t;

    typedef struct packed {
        bit_word_t bits;
    } slice_word_t;

    typedef struct packed {
        err_t [LANES-1:0] err;
        bit_word_t        bits;
    } error_word_t;

    typedef enum logic [1:0] {
        HYP_NONE      = 2'd0,
        HYP_FLIP_ONE  = 2'd1,
        HYP_FLIP_PAIR = 2'd2
    } err_pos_e;

    typedef err_pos_e [LANES-1:0] hyp_word_t;

endpackage

`default_nettype wire

// File: design/code_history.sv
`timescale 1ns/1ns
`default_nettype none

module code_history
    import dsp_pkg::*;
#(
    parameter int DEPTH = 3
) (
    input  logic             clk,
    input  logic             reset_i,
    input  code_word_t       codes_i,
    output code_word_t [1:0] window_o,
    output code_word_t       aligned_o
);

    code_word_t hist_q [DEPTH];

    // Entry 0 is the newest word
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                hist_q[i] <= '0;
            end
        end else begin
            hist_q[0] <= codes_i;
            for (int i = 1; i < DEPTH; i++) begin
                hist_q[i] <= hist_q[i-1];
            end
        end
    end

    assign window_o[0] = hist_q[0];
    assign window_o[1] = hist_q[1];

    // Oldest entry lines up with the rebuilt codes
    assign aligned_o = hist_q[DEPTH-1];

    depth_check: assert property (@(posedge clk) DEPTH >= 2)
        else $error("code history needs at least two words, DEPTH=%0d", DEPTH);

endmodule

`default_nettype wire

// File: design/ffe_slicer.sv
`timescale 1ns/1ns
`default_nettype none

module ffe_slicer
    import dsp_pkg::*;
#(
    parameter int FFE_TAPS = 3
) (
    input  logic               clk,
    input  logic               reset_i,
    input  code_word_t [1:0]   window_i,
    input  tap_set_t           weights_i,
    input  logic [SHIFT_W-1:0] shift_i,
    output slice_word_t        slice_o
);

    code_t       serial [2*LANES];
    est_t        acc [LANES];
    est_t        est [LANES];
    bit_word_t   bits;
    logic        window_valid_q;
    slice_word_t slice_q;

    // Previous word first, then the newest
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            serial[i]         = window_i[1][i];
            serial[LANES + i] = window_i[0][i];
        end
    end

    // FIR over the serial stream, reaching back into the previous word
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            acc[l] = '0;
            for (int j = 0; j < MAX_TAPS; j++) begin
                if (j < FFE_TAPS) begin
                    acc[l] = acc[l] + est_t'(weights_i[j] * serial[LANES + l - j]);
                end
            end
            est[l]  = acc[l] >>> shift_i;
            // Slice at zero
            bits[l] = ~est[l][EST_W-1];
        end
    end

    // The first window after reset is still all history, so keep bits at 0 for it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            window_valid_q <= 1'b0;
            slice_q        <= '0;
        end else begin
            window_valid_q <= 1'b1;
            if (window_valid_q) begin
                slice_q.bits <= bits;
            end
        end
    end

    assign slice_o = slice_q;

    shift_range: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown(shift_i) && int'(shift_i) <= 15)
        else $error("FFE shift out of range or unknown: %0d", shift_i);

endmodule

`default_nettype wire

// File: design/channel_filter.sv
`timescale 1ns/1ns
`default_nettype none

module channel_filter
    import dsp_pkg::*;
#(
    parameter int CHAN_TAPS = 3
) (
    input  logic               clk,
    input  logic               reset_i,
    input  slice_word_t        slice_i,
    input  tap_set_t           taps_i,
    input  logic [SHIFT_W-1:0] shift_i,
    output est_word_t          codes_o,
    output bit_word_t          bits_o
);

    bit_word_t prev_bits_q;
    logic      serial_bits [2*LANES];
    est_t      acc [LANES];
    est_word_t codes_d;
    est_word_t codes_q;
    bit_word_t bits_q;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            serial_bits[i]         = prev_bits_q[i];
            serial_bits[LANES + i] = slice_i.bits[i];
        end
    end

    // Each bit adds its tap as +tap or -tap
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            acc[l] = '0;
            for (int j = 0; j < MAX_TAPS; j++) begin
                if (j < CHAN_TAPS) begin
                    if (serial_bits[LANES + l - j]) begin
                        acc[l] = acc[l] + est_t'(taps_i[j]);
                    end else begin
                        acc[l] = acc[l] - est_t'(taps_i[j]);
                    end
                end
            end
            codes_d[l] = acc[l] >>> shift_i;
        end
    end

    // Previous bits start as symbol -1
    always_ff @(posedge clk) begin
        if (reset_i) begin
            prev_bits_q <= '0;
            codes_q     <= '0;
            bits_q      <= '0;
        end else begin
            prev_bits_q <= slice_i.bits;
            codes_q     <= codes_d;
            bits_q      <= slice_i.bits;
        end
    end

    assign codes_o = codes_q;
    assign bits_o  = bits_q;

endmodule

`default_nettype wire

// File: design/error_detector.sv
`timescale 1ns/1ns
`default_nettype none

module error_detector
    import dsp_pkg::*;
#(
    parameter int CHAN_TAPS = 3
) (
    input  logic       clk,
    input  logic       reset_i,
    input  est_word_t  est_i,
    input  bit_word_t  bits_i,
    input  code_word_t codes_i,
    input  tap_set_t   taps_i,
    output hyp_word_t  err_pos_o
);

    localparam int WIDE_W = ERR_W + 1;
    // Room for two injected tap terms, then squares of four samples
    localparam int INJ_W  = ERR_W + 3;
    localparam int EN_W   = 2*INJ_W + 2;

    logic signed [WIDE_W-1:0] diff [LANES];
    error_word_t              err_cur;
    error_word_t              err_prev_q;
    err_t                     err_seq [2*LANES];
    logic                     bit_seq [2*LANES];
    logic [EN_W-1:0]          en_none [LANES];
    logic [EN_W-1:0]          en_one [LANES];
    logic [EN_W-1:0]          en_pair [LANES];
    hyp_word_t                hyp_d;
    hyp_word_t                hyp_q;

    function automatic logic signed [INJ_W-1:0] flip_delta(input tap_t tap, input logic b);
        logic signed [INJ_W-1:0] twice;
        twice = INJ_W'(tap) <<< 1;
        return b ? twice : -twice;
    endfunction

    function automatic logic [EN_W-1:0] square(input logic signed [INJ_W-1:0] v);
        return EN_W'(v * v);
    endfunction

    // Error is rebuilt minus received
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            diff[l]        = WIDE_W'(est_i[l]) - WIDE_W'(codes_i[l]);
            err_cur.err[l] = err_t'(diff[l]);
        end
        err_cur.bits = bits_i;
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            err_seq[i]         = err_prev_q.err[i];
            err_seq[LANES + i] = err_cur.err[i];
            bit_seq[i]         = err_prev_q.bits[i];
            bit_seq[LANES + i] = err_cur.bits[i];
        end
    end

    // Hypotheses for each lane of the previous word, window of four samples
    always_comb begin
        logic signed [INJ_W-1:0] base;
        logic signed [INJ_W-1:0] one;
        logic signed [INJ_W-1:0] pair;
        for (int l = 0; l < LANES; l++) begin
            en_none[l] = '0;
            en_one[l]  = '0;
            en_pair[l] = '0;
            for (int k = 0; k < LANES; k++) begin
                base = INJ_W'(err_seq[l + k]);
                one  = base;
                if (k < CHAN_TAPS) begin
                    one = one - flip_delta(taps_i[k], bit_seq[l]);
                end
                en_none[l] = en_none[l] + square(base);
                en_one[l]  = en_one[l] + square(one);
                if (k == 0) begin
                    en_pair[l] = en_pair[l] + square(one);
                end
            end
            // Second flipped bit reaches one sample later
            for (int k = 1; k < LANES; k++) begin
                pair = INJ_W'(err_seq[l + k]);
                if (k < CHAN_TAPS) begin
                    pair = pair - flip_delta(taps_i[k], bit_seq[l]);
                end
                if (k - 1 < CHAN_TAPS) begin
                    pair = pair - flip_delta(taps_i[k-1], bit_seq[l + 1]);
                end
                en_pair[l] = en_pair[l] + square(pair);
            end
            // Strict compare keeps ties on the earlier hypothesis
            hyp_d[l] = HYP_NONE;
            if (en_one[l] < en_none[l]) begin
                hyp_d[l] = HYP_FLIP_ONE;
            end
            if (en_pair[l] < ((en_one[l] < en_none[l]) ? en_one[l] : en_none[l])) begin
                hyp_d[l] = HYP_FLIP_PAIR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            err_prev_q <= '0;
            for (int l = 0; l < LANES; l++) begin
                hyp_q[l] <= HYP_NONE;
            end
        end else begin
            err_prev_q <= err_cur;
            hyp_q      <= hyp_d;
        end
    end

    assign err_pos_o = hyp_q;

    for (genvar l = 0; l < LANES; l++) begin : g_check
        err_fits: assert property (@(posedge clk) disable iff (reset_i)
            diff[l] == WIDE_W'(err_cur.err[l]))
            else $error("error lane %0d overflows ERR_W", l);

        hyp_legal: assert property (@(posedge clk) disable iff (reset_i)
            err_pos_o[l] inside {HYP_NONE, HYP_FLIP_ONE, HYP_FLIP_PAIR})
            else $error("unused hypothesis code on lane %0d", l);
    end

endmodule

`default_nettype wire

// File: design/datapath_core.sv
`timescale 1ns/1ns
`default_nettype none

module datapath_core
    import dsp_pkg::*;
#(
    parameter int FFE_TAPS  = 3,
    parameter int CHAN_TAPS = 3
) (
    input  logic               clk,
    input  logic               reset_i,
    input  code_word_t         adc_codes_i,
    input  tap_set_t           ffe_weights_i,
    input  tap_set_t           chan_taps_i,
    input  logic [SHIFT_W-1:0] ffe_shift_i,
    input  logic [SHIFT_W-1:0] chan_shift_i,
    output bit_word_t          bits_o,
    output hyp_word_t          err_pos_o
);

    // Codes wait for slicer plus channel filter
    localparam int HIST_DEPTH = 3;

    code_word_t [1:0] code_window;
    code_word_t       aligned_codes;
    slice_word_t      ffe_slice;
    est_word_t        rebuilt_codes;
    bit_word_t        rebuilt_bits;

    code_history #(
        .DEPTH     (HIST_DEPTH)
    ) code_history_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .codes_i   (adc_codes_i),
        .window_o  (code_window),
        .aligned_o (aligned_codes)
    );

    ffe_slicer #(
        .FFE_TAPS  (FFE_TAPS)
    ) ffe_slicer_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .window_i  (code_window),
        .weights_i (ffe_weights_i),
        .shift_i   (ffe_shift_i),
        .slice_o   (ffe_slice)
    );

    channel_filter #(
        .CHAN_TAPS (CHAN_TAPS)
    ) channel_filter_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .slice_i   (ffe_slice),
        .taps_i    (chan_taps_i),
        .shift_i   (chan_shift_i),
        .codes_o   (rebuilt_codes),
        .bits_o    (rebuilt_bits)
    );

    error_detector #(
        .CHAN_TAPS (CHAN_TAPS)
    ) error_detector_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .est_i     (rebuilt_codes),
        .bits_i    (rebuilt_bits),
        .codes_i   (aligned_codes),
        .taps_i    (chan_taps_i),
        .err_pos_o (err_pos_o)
    );

    assign bits_o = ffe_slice.bits;

endmodule

`default_nettype wire

// File: bench/dsp_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_checker
    import dsp_pkg::*;
#(
    parameter int FFE_TAPS  = 3,
    parameter int CHAN_TAPS = 3
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire code_word_t         codes_i,
    input  wire tap_set_t           weights_i,
    input  wire tap_set_t           taps_i,
    input  wire logic [SHIFT_W-1:0] ffe_shift_i,
    input  wire logic [SHIFT_W-1:0] chan_shift_i,
    input  wire bit_word_t          bits_i,
    input  wire hyp_word_t          err_pos_i
);

    localparam int MEM_SAMPLES = 2048;

    // Serial stream since the last reset, samples before it count as code 0 and bit 0
    int    code_mem [MEM_SAMPLES];
    int    bit_mem [MEM_SAMPLES];
    int    clean_cnt;
    logic  prev_reset = 1'b0;
    string test_name = "none";
    int    test_checks;
    int    test_errors;
    int    total_checks = 0;
    int    total_errors = 0;

    function automatic int code_at(input int s);
        return (s < 0) ? 0 : code_mem[s];
    endfunction

    function automatic int sym_at(input int s);
        if (s < 0) begin
            return -1;
        end
        return (bit_mem[s] != 0) ? 1 : -1;
    endfunction

    function automatic int slice_bit(input int s);
        int acc;
        acc = 0;
        for (int j = 0; j < FFE_TAPS; j++) begin
            acc += int'(weights_i[j]) * code_at(s - j);
        end
        acc = acc >>> ffe_shift_i;
        return (acc >= 0) ? 1 : 0;
    endfunction

    function automatic int err_at(input int s);
        int acc;
        acc = 0;
        for (int j = 0; j < CHAN_TAPS; j++) begin
            acc += int'(taps_i[j]) * sym_at(s - j);
        end
        acc = acc >>> chan_shift_i;
        return acc - code_at(s);
    endfunction

    // Energy over samples n..n+3 for no flip, flip of n, flip of n and n+1
    function automatic err_pos_e hyp_at(input int n);
        longint e_none;
        longint e_one;
        longint e_pair;
        longint base;
        longint one;
        longint pair;
        e_none = 0;
        e_one  = 0;
        e_pair = 0;
        for (int k = 0; k < 4; k++) begin
            base = err_at(n + k);
            one  = base;
            if (k < CHAN_TAPS) begin
                one = one - 2 * int'(taps_i[k]) * sym_at(n);
            end
            pair = one;
            if (k >= 1 && k - 1 < CHAN_TAPS) begin
                pair = pair - 2 * int'(taps_i[k-1]) * sym_at(n + 1);
            end
            e_none += base * base;
            e_one  += one * one;
            e_pair += pair * pair;
        end
        if (e_pair < e_none && e_pair < e_one) begin
            return HYP_FLIP_PAIR;
        end else if (e_one < e_none) begin
            return HYP_FLIP_ONE;
        end
        return HYP_NONE;
    endfunction

    function automatic bit_word_t word_bits(input int k);
        bit_word_t b;
        for (int l = 0; l < LANES; l++) begin
            b[l] = (4*k + l < 0) ? 1'b0 : bit_mem[4*k + l][0];
        end
        return b;
    endfunction

    function automatic hyp_word_t word_hyp(input int k);
        hyp_word_t h;
        for (int l = 0; l < LANES; l++) begin
            h[l] = hyp_at(4*k + l);
        end
        return h;
    endfunction

    task automatic compare(input string what, input logic [7:0] exp, input logic [7:0] act);
        test_checks++;
        total_checks++;
        if (exp !== act) begin
            test_errors++;
            total_errors++;
            $display("[ERROR] %s %s at clean cycle %0d: expected %h, actual %h",
                test_name, what, clean_cnt, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %-16s %0d checks, %0d errors, %s", test_name, test_checks,
            test_errors, (test_errors == 0) ? "ok" : "FAILED");
    endtask

    always @(negedge clk) begin
        if (reset_i) begin
            // Outputs reflect a reset edge only once reset was seen before
            if (prev_reset) begin
                compare("bits_o", 8'h00, 8'(bits_i));
                compare("err_pos_o", 8'h00, 8'(err_pos_i));
            end
            clean_cnt = 0;
        end else if (clean_cnt < MEM_SAMPLES / LANES - 1) begin
            compare("bits_o", 8'(word_bits(clean_cnt - 2)), 8'(bits_i));
            // The second clean output still mixes reset values into its window
            if (clean_cnt < 2) begin
                compare("err_pos_o", 8'h00, 8'(err_pos_i));
            end else if (clean_cnt > 2) begin
                compare("err_pos_o", 8'(word_hyp(clean_cnt - 5)), 8'(err_pos_i));
            end
            for (int l = 0; l < LANES; l++) begin
                code_mem[4*clean_cnt + l] = int'(codes_i[l]);
            end
            for (int l = 0; l < LANES; l++) begin
                bit_mem[4*clean_cnt + l] = slice_bit(4*clean_cnt + l);
            end
            clean_cnt++;
        end
        prev_reset = reset_i;
    end

endmodule

`default_nettype wire

// File: bench/tb_datapath_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_datapath_core
    import dsp_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 200;
    localparam int NUM_TESTS    = 4;
    localparam int CYCLE_LIMIT  = (3 * NUM_TESTS * (RESET_CYCLES + RUN_CYCLES)) / 2;

    logic               clk = 1'b0;
    logic               reset_i = 1'b1;
    code_word_t         adc_codes = '0;
    tap_set_t           ffe_weights = '0;
    tap_set_t           chan_taps = '0;
    logic [SHIFT_W-1:0] ffe_shift = '0;
    logic [SHIFT_W-1:0] chan_shift = '0;
    bit_word_t          bits;
    hyp_word_t          err_pos;

    logic [31:0] rng_state = 32'h32ffccff;
    int          match_tap = 1;
    int          cycle_count = 0;

    always #5 clk = ~clk;

    datapath_core #(
        .FFE_TAPS      (3),
        .CHAN_TAPS     (3)
    ) dut_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .adc_codes_i   (adc_codes),
        .ffe_weights_i (ffe_weights),
        .chan_taps_i   (chan_taps),
        .ffe_shift_i   (ffe_shift),
        .chan_shift_i  (chan_shift),
        .bits_o        (bits),
        .err_pos_o     (err_pos)
    );

    dsp_checker #(
        .FFE_TAPS     (3),
        .CHAN_TAPS    (3)
    ) checker_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .codes_i      (adc_codes),
        .weights_i    (ffe_weights),
        .taps_i       (chan_taps),
        .ffe_shift_i  (ffe_shift),
        .chan_shift_i (chan_shift),
        .bits_i       (bits),
        .err_pos_i    (err_pos)
    );

    function automatic logic [7:0] rand_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        // Upper bits of the LCG are the better ones
        return rng_state[31:24];
    endfunction

    task automatic set_config(input int mode);
        for (int j = 0; j < MAX_TAPS; j++) begin
            chan_taps[j]   = rand_byte();
            ffe_weights[j] = (mode == 1 || mode == 3) ? rand_byte() : 8'h00;
        end
        chan_shift = SHIFT_W'(rand_byte());
        ffe_shift  = (mode == 1 || mode == 3) ? SHIFT_W'(rand_byte()) : '0;
        if (mode == 0 || mode == 2) begin
            ffe_weights[0] = 8'sd1;
        end
        // Single tap channel that the codes are built through
        if (mode == 2) begin
            match_tap    = 1 + int'(rand_byte()) % 127;
            chan_taps    = '0;
            chan_taps[0] = 8'(match_tap);
            chan_shift   = '0;
        end
    endtask

    task automatic drive_word(input int mode);
        logic [7:0] r;
        for (int l = 0; l < LANES; l++) begin
            r = rand_byte();
            if (mode == 2) begin
                adc_codes[l] = r[7] ? 8'(match_tap) : 8'(-match_tap);
            end else begin
                adc_codes[l] = r;
            end
        end
    endtask

    task automatic run_test(input string name, input int mode);
        set_config(mode);
        checker_i.begin_test(name);
        reset_i   = 1'b1;
        adc_codes = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
        end
        reset_i = 1'b0;
        repeat (RUN_CYCLES) begin
            drive_word(mode);
            @(posedge clk);
            #1;
        end
        checker_i.end_test();
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped: cycle limit of %0d reached before the tests ended",
                CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        run_test("identity_ffe", 0);
        run_test("random_ffe", 1);
        run_test("matched_channel", 2);
        run_test("random_channel", 3);
        $display("checks %0d, errors %0d", checker_i.total_checks, checker_i.total_errors);
        if (checker_i.total_checks == 0) begin
            $display("No output was compared during the run");
        end
        if (checker_i.total_errors == 0 && checker_i.total_checks > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/dsp_pkg.sv
design/code_history.sv
design/ffe_slicer.sv
design/channel_filter.sv
design/error_detector.sv
design/datapath_core.sv
bench/dsp_checker.sv
bench/tb_datapath_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the datapath core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_datapath_core \
    -f files.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log
